// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_lc4
FILELIST  ?= tb.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// architectural state of the reference machine
logic [15:0] ref_regs [8];
logic [2:0]  ref_nzp;
logic [15:0] ref_pc;
logic [15:0] ref_mem [logic [15:0]];
bit          ref_taken;        // last stepped instruction changed the flow

function automatic logic [2:0] sign_flags(input logic [15:0] v);
  if (v[15]) begin
    return 3'b100;
  end
  if (v == 16'h0000) begin
    return 3'b010;
  end
  return 3'b001;
endfunction

function automatic void ref_reset();
  for (int i = 0; i < 8; i++) begin
    ref_regs[i] = 16'h0000;
  end
  ref_nzp   = 3'b000;            // no writer yet, so no branch is taken
  ref_pc    = `LC4_RESET_PC;
  ref_taken = 1'b0;
  ref_mem.delete();
endfunction

// runs the instruction at ref_pc and returns what it should retire as
function automatic trace_t ref_step();
  insn_u       in;
  trace_t      t;
  logic [15:0] a;
  logic [15:0] b;
  logic [15:0] r;
  logic [15:0] addr;
  logic [15:0] idx;
  logic [15:0] target;
  logic        we;
  idx        = ref_pc - `LC4_RESET_PC;
  in         = prog[idx[9:0]];
  t          = '0;
  t.pc       = ref_pc;
  t.insn     = in;
  t.stall    = `LC4_STALL_NONE;
  we         = 1'b0;
  r          = 16'h0000;
  ref_taken  = 1'b0;
  target     = ref_pc + 16'd1;
  a          = ref_regs[in.ri.rs];
  b          = in.ri.flag ? {{11{in.ri.imm5[4]}}, in.ri.imm5} : ref_regs[in.rr.rt];
  addr       = ref_regs[in.mem.rs] + {{10{in.mem.imm6[5]}}, in.mem.imm6};
  case (in.rr.op)
    `LC4_OP_ARITH: begin
      r  = (!in.ri.flag && in.rr.sub == `LC4_OP_SUB) ? a - b : a + b;
      we = 1'b1;
    end
    `LC4_OP_LOGIC: begin
      if (!in.ri.flag && in.rr.sub == `LC4_OP_OR) begin
        r = a | b;
      end else if (!in.ri.flag && in.rr.sub == `LC4_OP_XOR) begin
        r = a ^ b;
      end else begin
        r = a & b;
      end
      we = 1'b1;
    end
    `LC4_OP_LDR: begin
      r           = ref_mem.exists(addr) ? ref_mem[addr] : 16'h0000;
      t.dmem_addr = addr;
      t.dmem_data = r;
      we          = 1'b1;
    end
    `LC4_OP_STR: begin
      t.dmem_we     = 1'b1;
      t.dmem_addr   = addr;
      t.dmem_data   = ref_regs[in.mem.rd];
      ref_mem[addr] = ref_regs[in.mem.rd];
    end
    `LC4_OP_CONST: begin
      r  = {{7{in.cst.imm9[8]}}, in.cst.imm9};
      we = 1'b1;
    end
    `LC4_OP_BR: begin
      ref_taken = |(in.br.nzp & ref_nzp);
      target    = ref_pc + 16'd1 + {{7{in.br.imm9[8]}}, in.br.imm9};
    end
    `LC4_OP_JMP: begin
      ref_taken = in.jmp.flag;
      target    = ref_pc + 16'd1 + {{5{in.jmp.imm11[10]}}, in.jmp.imm11};
    end
    default: ;                   // anything else retires with no writes
  endcase
  if (we) begin
    t.regfile_we        = 1'b1;
    t.wsel              = in.ri.rd;
    t.wdata             = r;
    t.nzp_we            = 1'b1;
    t.nzp               = sign_flags(r);
    ref_regs[in.ri.rd]  = r;
    ref_nzp             = t.nzp;
  end
  ref_pc = ref_taken ? target : ref_pc + 16'd1;
  return t;
endfunction

`endif

// File: bench/tb_lc4.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module tb_lc4 import lc4_pkg::*; ();

  localparam int N_RANDOM = 400;

  logic        gwe;
  logic        rst;
  logic [15:0] pc;
  logic [15:0] insn;
  logic [15:0] dmem_addr;
  logic        dmem_we;
  logic [15:0] dmem_wdata;
  logic [15:0] dmem_rdata;
  trace_t      trace;

  logic [15:0] prog [1024];               // word 0 sits at the reset pc
  logic [15:0] dmem [logic [15:0]];
  int          prog_len;
  int          halt_idx;
  bit          built;
  bit          done;
  int          errors;
  int          checks;
  int          retired;
  int          total_flush;
  int          total_load;
  logic [31:0] lfsr;

  `include "tb_ref_model.svh"

  lc4_core dut0 (
    .gwe          (gwe),
    .i_rst        (rst),
    .o_pc         (pc),
    .i_insn       (insn),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_we    (dmem_we),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata),
    .o_trace      (trace)
  );

  initial begin
    gwe = 1'b0;
    forever #2 gwe = ~gwe;
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic int rand_bits(input int n);
    int   v;
    logic fb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = (v << 1) | int'(fb);
    end
    return v;
  endfunction

  function automatic logic [15:0] enc_reg(input logic [3:0] op, input int rd, input int rs,
                                          input logic [2:0] sub, input int rt);
    return {op, rd[2:0], rs[2:0], sub, rt[2:0]};
  endfunction

  function automatic logic [15:0] enc_imm(input logic [3:0] op, input int rd, input int rs,
                                          input int imm);
    return {op, rd[2:0], rs[2:0], 1'b1, imm[4:0]};
  endfunction

  function automatic logic [15:0] enc_mem(input logic [3:0] op, input int rd, input int rs,
                                          input int imm);
    return {op, rd[2:0], rs[2:0], imm[5:0]};
  endfunction

  function automatic logic [15:0] enc_const(input int rd, input int imm);
    return {`LC4_OP_CONST, rd[2:0], imm[8:0]};
  endfunction

  function automatic logic [15:0] enc_br(input int nzp, input int off);
    return {`LC4_OP_BR, nzp[2:0], off[8:0]};
  endfunction

  function automatic logic [15:0] enc_jmp(input int off);
    return {`LC4_OP_JMP, 1'b1, off[10:0]};
  endfunction

  task automatic emit(input logic [15:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // forward-only flow changes keep the program finite
  function automatic logic [15:0] random_insn(input int idx);
    int kind;
    int rd;
    int rs;
    int rt;
    int off;
    kind = rand_bits(4);
    rd   = rand_bits(3);
    rs   = rand_bits(3);
    rt   = rand_bits(3);
    off  = rand_bits(3);
    if (off > halt_idx - idx - 1) begin
      off = halt_idx - idx - 1;
    end
    case (kind)
      0, 1:   return enc_reg(`LC4_OP_ARITH, rd, rs, `LC4_OP_ADD, rt);
      2:      return enc_reg(`LC4_OP_ARITH, rd, rs, `LC4_OP_SUB, rt);
      3:      return enc_imm(`LC4_OP_ARITH, rd, rs, rand_bits(5));
      4:      return enc_reg(`LC4_OP_LOGIC, rd, rs, `LC4_OP_AND, rt);
      5:      return enc_reg(`LC4_OP_LOGIC, rd, rs, `LC4_OP_OR, rt);
      6:      return enc_reg(`LC4_OP_LOGIC, rd, rs, `LC4_OP_XOR, rt);
      7:      return enc_imm(`LC4_OP_LOGIC, rd, rs, rand_bits(5));
      8, 9:   return enc_mem(`LC4_OP_LDR, rd, 6 | (rs & 1), rt);   // base r6 or r7
      10, 11: return enc_mem(`LC4_OP_STR, rd, 6 | (rs & 1), rt);
      12, 13: return enc_const(rd, rand_bits(9));
      14:     return enc_br((rd == 0) ? 7 : rd, off);
      default: return enc_jmp(off);
    endcase
  endfunction

  task automatic build_program();
    prog_len = 0;
    for (int i = 0; i < 1024; i++) begin
      prog[i] = 16'h0000;
    end
    emit(enc_const(1, 5));                                  // dependent chain that is fully bypassed
    emit(enc_imm(`LC4_OP_ARITH, 2, 1, 3));
    emit(enc_reg(`LC4_OP_ARITH, 3, 2, `LC4_OP_ADD, 1));
    emit(enc_reg(`LC4_OP_ARITH, 4, 3, `LC4_OP_SUB, 2));
    emit(enc_reg(`LC4_OP_LOGIC, 5, 4, `LC4_OP_XOR, 3));
    emit(enc_imm(`LC4_OP_LOGIC, 6, 5, 31));
    emit(enc_reg(`LC4_OP_LOGIC, 7, 6, `LC4_OP_OR, 1));
    emit(enc_const(7, 32));
    emit(enc_mem(`LC4_OP_STR, 3, 7, 1));
    emit(enc_mem(`LC4_OP_STR, 4, 7, 2));
    emit(enc_mem(`LC4_OP_LDR, 5, 7, 1));
    emit(enc_reg(`LC4_OP_ARITH, 6, 5, `LC4_OP_ADD, 5));    // load-use
    emit(enc_mem(`LC4_OP_LDR, 1, 7, 2));
    emit(enc_imm(`LC4_OP_ARITH, 2, 7, 0));                  // independent of the load
    emit(enc_reg(`LC4_OP_ARITH, 3, 1, `LC4_OP_ADD, 2));
    emit(enc_mem(`LC4_OP_LDR, 4, 7, 1));
    emit(enc_br(1, 1));                                     // reads nzp of the load
    emit(enc_const(0, 99));
    emit(enc_br(4, 3));                                     // not taken
    emit(enc_jmp(1));
    emit(enc_const(0, 77));
    emit(enc_const(0, -1));
    emit(enc_br(2, 2));
    emit(enc_br(4, 0));                                     // taken onto the next word
    halt_idx = prog_len + N_RANDOM;
    for (int i = 0; i < N_RANDOM; i++) begin
      emit(random_insn(prog_len));
    end
    emit(enc_jmp(-1));                                      // halt loop
  endtask

  // instruction and data memories answer from the settled address
  always @(posedge gwe) begin : memories
    logic [15:0] ia;
    #1;
    ia = pc - `LC4_RESET_PC;
    insn = (ia < 16'd1024) ? prog[ia[9:0]] : 16'h0000;
    if (dmem_we === 1'b1) begin
      dmem[dmem_addr] = dmem_wdata;
    end
    dmem_rdata = dmem.exists(dmem_addr) ? dmem[dmem_addr] : 16'h0000;
  end

  task automatic check_field(input string name, input logic [15:0] got,
                             input logic [15:0] want, input logic [15:0] at_pc);
    checks++;
    assert (got === want) else begin
      $display("FAIL %0t: pc %h %s is %h, expected %h", $time, at_pc, name, got, want);
      errors++;
    end
  endtask

  // load-to-use rule where a branch reads the nzp of the load
  function automatic bit reads_reg(input insn_u in, input logic [2:0] r);
    case (in.rr.op)
      `LC4_OP_ARITH, `LC4_OP_LOGIC: return in.ri.rs == r || (!in.ri.flag && in.rr.rt == r);
      `LC4_OP_LDR:   return in.mem.rs == r;
      `LC4_OP_STR:   return in.mem.rs == r || in.mem.rd == r;
      `LC4_OP_BR:    return in.br.nzp != 3'b000;
      default:       return 1'b0;
    endcase
  endfunction

  always @(negedge gwe) begin : trace_compare
    trace_t     want;
    int         want_load;
    static int  want_flush = 0;
    static int  n_flush = 0;
    static int  n_load = 0;
    static bit  started = 0;
    static bit  prev_load = 0;
    static logic [2:0] prev_rd = 3'd0;
    static logic        port_we = 1'b0;          // data port seen one cycle before writeback
    static logic [15:0] port_addr = 16'h0000;
    static logic [15:0] port_data = 16'h0000;
    if (!rst && !done) begin
      if (trace.stall == `LC4_STALL_FLUSH) begin
        n_flush++;
      end else if (trace.stall == `LC4_STALL_LOAD) begin
        n_load++;
      end else begin
        want = ref_step();
        check_field("insn", trace.insn, want.insn, want.pc);
        check_field("pc", trace.pc, want.pc, want.pc);
        check_field("stall", 16'(trace.stall), 16'(want.stall), want.pc);
        check_field("regfile_we", 16'(trace.regfile_we), 16'(want.regfile_we), want.pc);
        check_field("wsel", 16'(trace.wsel), 16'(want.wsel), want.pc);
        check_field("wdata", trace.wdata, want.wdata, want.pc);
        check_field("nzp_we", 16'(trace.nzp_we), 16'(want.nzp_we), want.pc);
        check_field("nzp", 16'(trace.nzp), 16'(want.nzp), want.pc);
        check_field("dmem_we", 16'(trace.dmem_we), 16'(want.dmem_we), want.pc);
        check_field("dmem_addr", trace.dmem_addr, want.dmem_addr, want.pc);
        check_field("dmem_data", trace.dmem_data, want.dmem_data, want.pc);
        check_field("port dmem_we", 16'(port_we), 16'(want.dmem_we), want.pc);
        if (want.dmem_we || want.insn[15:12] == `LC4_OP_LDR) begin
          check_field("port dmem_addr", port_addr, want.dmem_addr, want.pc);
        end
        if (want.dmem_we) begin
          check_field("port dmem_wdata", port_data, want.dmem_data, want.pc);
        end
        want_load = (prev_load && reads_reg(insn_u'(want.insn), prev_rd)) ? 1 : 0;
        if (started) begin
          checks++;
          assert (n_flush == want_flush && n_load == want_load) else begin
            $display("FAIL %0t: pc %h after %0d/%0d flush/load bubbles, expected %0d/%0d",
                     $time, want.pc, n_flush, n_load, want_flush, want_load);
            errors++;
          end
          total_flush += n_flush;
          total_load  += n_load;
        end
        want_flush = ref_taken ? 2 : 0;
        prev_load  = want.insn[15:12] == `LC4_OP_LDR;
        prev_rd    = want.wsel;
        n_flush    = 0;
        n_load     = 0;
        started    = 1'b1;
        retired++;
        if (want.pc == `LC4_RESET_PC + 16'(halt_idx)) begin
          done = 1'b1;
        end
      end
      port_we   = dmem_we;
      port_addr = dmem_addr;
      port_data = dmem_wdata;
    end
  end

  initial begin
    rst         = 1'b1;
    insn        = 16'h0000;
    dmem_rdata  = 16'h0000;
    lfsr        = 32'ha4adfbd5;
    errors      = 0;
    checks      = 0;
    retired     = 0;
    total_flush = 0;
    total_load  = 0;
    done        = 1'b0;
    ref_reset();
    build_program();
    built = 1'b1;
    repeat (9) @(posedge gwe);
    @(negedge gwe);
    check_field("reset pc", pc, `LC4_RESET_PC, pc);
    check_field("reset dmem_we", 16'(dmem_we), 16'h0000, pc);
    check_field("reset stall", 16'(trace.stall), 16'(`LC4_STALL_FLUSH), pc);
    check_field("reset regfile_we", 16'(trace.regfile_we), 16'h0000, pc);
    check_field("reset nzp_we", 16'(trace.nzp_we), 16'h0000, pc);
    check_field("reset trace dmem_we", 16'(trace.dmem_we), 16'h0000, pc);
    @(posedge gwe);
    #1 rst = 1'b0;
    wait (done);
    @(posedge gwe);
    $display("checks %0d errors %0d retired %0d flush bubbles %0d load bubbles %0d",
             checks, errors, retired, total_flush, total_load);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // every instruction costs at most three cycles
  initial begin : watchdog
    wait (built);
    repeat (prog_len * 3 + 100 + 10) @(posedge gwe);
    $display("timeout: the halt instruction did not retire within %0d cycles",
             prog_len * 3 + 100);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: common/lc4_cfg.svh
`ifndef LC4_CFG_SVH
`define LC4_CFG_SVH

`define LC4_RESET_PC   16'h8200        // first fetch after reset
`define LC4_WORD_W     16
`define LC4_REG_W      3

// major opcodes in insn[15:12]
`define LC4_OP_BR      4'b0000
`define LC4_OP_ARITH   4'b0001
`define LC4_OP_LOGIC   4'b0101
`define LC4_OP_LDR     4'b0110
`define LC4_OP_STR     4'b0111
`define LC4_OP_CONST   4'b1001
`define LC4_OP_JMP     4'b1100

// sub-ops in insn[5:3] for the register forms
`define LC4_OP_ADD     3'b000
`define LC4_OP_SUB     3'b010
`define LC4_OP_AND     3'b000
`define LC4_OP_OR      3'b010
`define LC4_OP_XOR     3'b011

`define LC4_STALL_NONE  2'd0
`define LC4_STALL_FLUSH 2'd2           // squashed by a redirect, also the reset state
`define LC4_STALL_LOAD  2'd3           // load-to-use bubble

`endif

// File: common/lc4_pkg.sv
`include "lc4_cfg.svh"

package lc4_pkg;

  typedef struct packed {
    logic [3:0]            op;
    logic [`LC4_REG_W-1:0] rd;
    logic [`LC4_REG_W-1:0] rs;
    logic [2:0]            sub;
    logic [`LC4_REG_W-1:0] rt;
  } insn_rr_t;

  typedef struct packed {
    logic [3:0]            op;
    logic [`LC4_REG_W-1:0] rd;
    logic [`LC4_REG_W-1:0] rs;
    logic                  flag;   // set for the immediate variant
    logic [4:0]            imm5;
  } insn_ri_t;

  typedef struct packed {
    logic [3:0]            op;
    logic [`LC4_REG_W-1:0] rd;     // source register for STR
    logic [`LC4_REG_W-1:0] rs;
    logic [5:0]            imm6;
  } insn_mem_t;

  typedef struct packed {
    logic [3:0]            op;
    logic [`LC4_REG_W-1:0] rd;
    logic [8:0]            imm9;
  } insn_cst_t;

  typedef struct packed {
    logic [3:0] op;
    logic [2:0] nzp;
    logic [8:0] imm9;
  } insn_br_t;

  typedef struct packed {
    logic [3:0]  op;
    logic        flag;             // 1 selects the pc-relative JMP
    logic [10:0] imm11;
  } insn_jmp_t;

  // one instruction word, read through whichever layout the opcode calls for
  typedef union packed {
    insn_rr_t  rr;
    insn_ri_t  ri;
    insn_mem_t mem;
    insn_cst_t cst;
    insn_br_t  br;
    insn_jmp_t jmp;
  } insn_u;

  typedef struct packed {
    logic [`LC4_REG_W-1:0] rs_sel;
    logic                  rs_re;
    logic [`LC4_REG_W-1:0] rt_sel;
    logic                  rt_re;
    logic [`LC4_REG_W-1:0] wsel;
    logic                  regfile_we;
    logic                  nzp_we;
    logic                  is_load;
    logic                  is_store;
    logic                  is_branch;
    logic                  is_jump;
  } ctrl_t;

  typedef struct packed {
    logic [`LC4_WORD_W-1:0] pc;
    insn_u                  insn;
  } fd_t;

  typedef struct packed {
    logic [`LC4_WORD_W-1:0] pc;
    insn_u                  insn;
    ctrl_t                  ctrl;
    logic [`LC4_WORD_W-1:0] rs_data;
    logic [`LC4_WORD_W-1:0] rt_data;
    logic [1:0]             stall;
  } dx_t;

  typedef struct packed {
    logic [`LC4_WORD_W-1:0] pc;
    insn_u                  insn;
    ctrl_t                  ctrl;
    logic [`LC4_WORD_W-1:0] result;
    logic [`LC4_WORD_W-1:0] store_data;
    logic [2:0]             nzp;
    logic [1:0]             stall;
  } xm_t;

  typedef struct packed {
    logic                   we;
    logic [`LC4_REG_W-1:0]  wsel;
    logic [`LC4_WORD_W-1:0] data;
  } fwd_t;

  typedef struct packed {
    logic [`LC4_WORD_W-1:0] pc;
    logic [`LC4_WORD_W-1:0] insn;
    logic [1:0]             stall;
    logic                   regfile_we;
    logic [`LC4_REG_W-1:0]  wsel;
    logic [`LC4_WORD_W-1:0] wdata;
    logic                   nzp_we;
    logic [2:0]             nzp;
    logic                   dmem_we;
    logic [`LC4_WORD_W-1:0] dmem_addr;
    logic [`LC4_WORD_W-1:0] dmem_data;
  } trace_t;

  function automatic logic [2:0] nzp_of(input logic [`LC4_WORD_W-1:0] v);
    return {v[`LC4_WORD_W-1], v == '0, !v[`LC4_WORD_W-1] && v != '0};
  endfunction

endpackage

// File: decode/decode_stage.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module decode_stage import lc4_pkg::*; (
  input  logic gwe,
  input  logic i_rst,
  input  fd_t  i_fd,
  input  fwd_t i_wr,
  input  logic i_redirect,
  output logic o_stall,
  output dx_t  o_dx
);

  ctrl_t                  ctrl;
  logic                   rr_ok;        // register-form sub-op is one we implement
  logic [`LC4_WORD_W-1:0] rs_data;
  logic [`LC4_WORD_W-1:0] rt_data;
  logic                   fd_bubble;    // fd holds a squashed slot
  dx_t                    dx_n;
  dx_t                    dx_q;

  regfile rf0 (
    .gwe       (gwe),
    .i_rst     (i_rst),
    .i_rs_sel  (ctrl.rs_sel),
    .i_rt_sel  (ctrl.rt_sel),
    .i_wr      (i_wr),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  assign rr_ok = (i_fd.insn.rr.op == `LC4_OP_ARITH) ?
                 (i_fd.insn.rr.sub == `LC4_OP_ADD || i_fd.insn.rr.sub == `LC4_OP_SUB) :
                 (i_fd.insn.rr.sub == `LC4_OP_AND || i_fd.insn.rr.sub == `LC4_OP_OR ||
                  i_fd.insn.rr.sub == `LC4_OP_XOR);

  always_comb begin
    ctrl = '0;
    case (i_fd.insn.rr.op)
      `LC4_OP_ARITH, `LC4_OP_LOGIC: begin
        ctrl.rs_sel = i_fd.insn.rr.rs;
        ctrl.rt_sel = i_fd.insn.rr.rt;
        ctrl.wsel   = i_fd.insn.rr.rd;
        if (i_fd.insn.ri.flag || rr_ok) begin
          ctrl.rs_re      = 1'b1;
          ctrl.rt_re      = !i_fd.insn.ri.flag;   // imm5 replaces rt
          ctrl.regfile_we = 1'b1;
          ctrl.nzp_we     = 1'b1;
        end
      end
      `LC4_OP_LDR: begin
        ctrl.rs_sel     = i_fd.insn.mem.rs;
        ctrl.rs_re      = 1'b1;
        ctrl.wsel       = i_fd.insn.mem.rd;
        ctrl.regfile_we = 1'b1;
        ctrl.nzp_we     = 1'b1;
        ctrl.is_load    = 1'b1;
      end
      `LC4_OP_STR: begin
        ctrl.rs_sel   = i_fd.insn.mem.rs;
        ctrl.rs_re    = 1'b1;
        ctrl.rt_sel   = i_fd.insn.mem.rd;   // store data
        ctrl.rt_re    = 1'b1;
        ctrl.is_store = 1'b1;
      end
      `LC4_OP_CONST: begin
        ctrl.wsel       = i_fd.insn.cst.rd;
        ctrl.regfile_we = 1'b1;
        ctrl.nzp_we     = 1'b1;
      end
      `LC4_OP_BR:  ctrl.is_branch = |i_fd.insn.br.nzp;   // nzp=000 is a plain nop
      `LC4_OP_JMP: ctrl.is_jump   = i_fd.insn.jmp.flag;
      default: ;                                         // unsupported, retires as nop
    endcase
  end

  // load in execute feeding decode, a branch counts since the load sets nzp
  assign o_stall = !fd_bubble && dx_q.ctrl.is_load &&
                   ((ctrl.rs_re && ctrl.rs_sel == dx_q.ctrl.wsel) ||
                    (ctrl.rt_re && ctrl.rt_sel == dx_q.ctrl.wsel) ||
                    ctrl.is_branch);

  always_comb begin
    dx_n.pc      = i_fd.pc;
    dx_n.insn    = i_fd.insn;
    dx_n.ctrl    = ctrl;
    dx_n.rs_data = rs_data;
    dx_n.rt_data = rt_data;
    dx_n.stall   = `LC4_STALL_NONE;
    if (i_redirect || fd_bubble) begin
      dx_n.insn  = '0;
      dx_n.ctrl  = '0;
      dx_n.stall = `LC4_STALL_FLUSH;
    end else if (o_stall) begin
      dx_n.insn  = '0;
      dx_n.ctrl  = '0;
      dx_n.stall = `LC4_STALL_LOAD;
    end
  end

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      fd_bubble  <= 1'b1;
      dx_q       <= '0;
      dx_q.stall <= `LC4_STALL_FLUSH;
    end else begin
      if (i_redirect) begin
        fd_bubble <= 1'b1;
      end else if (!o_stall) begin
        fd_bubble <= 1'b0;       // fd reloads with a fresh fetch
      end
      dx_q <= dx_n;
    end
  end

  assign o_dx = dx_q;

endmodule

// File: decode/regfile.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module regfile import lc4_pkg::*; (
  input  logic                   gwe,
  input  logic                   i_rst,
  input  logic [`LC4_REG_W-1:0]  i_rs_sel,
  input  logic [`LC4_REG_W-1:0]  i_rt_sel,
  input  fwd_t                   i_wr,
  output logic [`LC4_WORD_W-1:0] o_rs_data,
  output logic [`LC4_WORD_W-1:0] o_rt_data
);

  logic [`LC4_WORD_W-1:0] regs [2**`LC4_REG_W];

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      for (int i = 0; i < 2**`LC4_REG_W; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.we) begin
      regs[i_wr.wsel] <= i_wr.data;
    end
  end

  // write-through, a read in the cycle of the write sees the new value
  assign o_rs_data = (i_wr.we && i_wr.wsel == i_rs_sel) ? i_wr.data : regs[i_rs_sel];
  assign o_rt_data = (i_wr.we && i_wr.wsel == i_rt_sel) ? i_wr.data : regs[i_rt_sel];

endmodule

// File: execute/execute_stage.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module execute_stage import lc4_pkg::*; (
  input  logic                   gwe,
  input  logic                   i_rst,
  input  dx_t                    i_dx,
  input  fwd_t                   i_m_fwd,
  input  fwd_t                   i_w_fwd,
  input  logic [2:0]             i_nzp,
  output logic                   o_redirect,
  output logic [`LC4_WORD_W-1:0] o_target,
  output xm_t                    o_xm
);

  logic [`LC4_WORD_W-1:0] op_a;
  logic [`LC4_WORD_W-1:0] op_b;
  logic [`LC4_WORD_W-1:0] pc_inc;
  logic [`LC4_WORD_W-1:0] result;
  logic [2:0]             br_nzp;
  xm_t                    xm_q;

  // memory stage is younger than writeback so it goes first
  function automatic logic [`LC4_WORD_W-1:0] bypass(
    input logic [`LC4_REG_W-1:0]  sel,
    input logic [`LC4_WORD_W-1:0] reg_val,
    input fwd_t                   m,
    input fwd_t                   w
  );
    logic [`LC4_WORD_W-1:0] v;
    v = reg_val;
    if (m.we && m.wsel == sel) begin
      v = m.data;
    end else if (w.we && w.wsel == sel) begin
      v = w.data;
    end
    return v;
  endfunction

  assign op_a   = bypass(i_dx.ctrl.rs_sel, i_dx.rs_data, i_m_fwd, i_w_fwd);
  assign op_b   = bypass(i_dx.ctrl.rt_sel, i_dx.rt_data, i_m_fwd, i_w_fwd);
  assign pc_inc = i_dx.pc + 16'd1;

  always_comb begin
    result = op_a + op_b;
    case (i_dx.insn.rr.op)
      `LC4_OP_ARITH: begin
        if (i_dx.insn.ri.flag) begin
          result = op_a + {{11{i_dx.insn.ri.imm5[4]}}, i_dx.insn.ri.imm5};
        end else if (i_dx.insn.rr.sub == `LC4_OP_SUB) begin
          result = op_a - op_b;
        end
      end
      `LC4_OP_LOGIC: begin
        if (i_dx.insn.ri.flag) begin
          result = op_a & {{11{i_dx.insn.ri.imm5[4]}}, i_dx.insn.ri.imm5};
        end else if (i_dx.insn.rr.sub == `LC4_OP_OR) begin
          result = op_a | op_b;
        end else if (i_dx.insn.rr.sub == `LC4_OP_XOR) begin
          result = op_a ^ op_b;
        end else begin
          result = op_a & op_b;
        end
      end
      `LC4_OP_LDR, `LC4_OP_STR: result = op_a + {{10{i_dx.insn.mem.imm6[5]}}, i_dx.insn.mem.imm6};
      `LC4_OP_CONST: result = {{7{i_dx.insn.cst.imm9[8]}}, i_dx.insn.cst.imm9};
      `LC4_OP_BR:    result = pc_inc + {{7{i_dx.insn.br.imm9[8]}}, i_dx.insn.br.imm9};
      `LC4_OP_JMP:   result = pc_inc + {{5{i_dx.insn.jmp.imm11[10]}}, i_dx.insn.jmp.imm11};
      default: ;
    endcase
  end

  // every register writer in this subset also writes nzp, so the bypass
  // data gives the in-flight condition codes
  always_comb begin
    if (i_m_fwd.we) begin
      br_nzp = nzp_of(i_m_fwd.data);
    end else if (i_w_fwd.we) begin
      br_nzp = nzp_of(i_w_fwd.data);
    end else begin
      br_nzp = i_nzp;
    end
  end

  assign o_redirect = i_dx.ctrl.is_jump ||
                      (i_dx.ctrl.is_branch && |(i_dx.insn.br.nzp & br_nzp));
  assign o_target   = result;

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      xm_q       <= '0;
      xm_q.stall <= `LC4_STALL_FLUSH;
    end else begin
      xm_q.pc         <= i_dx.pc;
      xm_q.insn       <= i_dx.insn;
      xm_q.ctrl       <= i_dx.ctrl;
      xm_q.result     <= result;
      xm_q.store_data <= op_b;              // bypassed rt
      xm_q.nzp        <= nzp_of(result);    // loads fix this up in writeback
      xm_q.stall      <= i_dx.stall;
    end
  end

  assign o_xm = xm_q;

  // decode must hand over bubbles with control cleared
  assert property (@(posedge gwe) disable iff (i_rst)
    (i_dx.stall != `LC4_STALL_NONE) |-> !o_redirect)
    else $error("redirect raised by a bubble");

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module fetch_unit import lc4_pkg::*; (
  input  logic                   gwe,
  input  logic                   i_rst,
  input  logic                   i_stall,
  input  logic                   i_redirect,
  input  logic [`LC4_WORD_W-1:0] i_target,
  input  logic [`LC4_WORD_W-1:0] i_insn,
  output logic [`LC4_WORD_W-1:0] o_pc,
  output fd_t                    o_fd
);

  logic [`LC4_WORD_W-1:0] pc_q;
  logic [`LC4_WORD_W-1:0] pc_n;

  // redirect wins over a load stall
  always_comb begin
    if (i_redirect) begin
      pc_n = i_target;
    end else if (i_stall) begin
      pc_n = pc_q;
    end else begin
      pc_n = pc_q + 16'd1;
    end
  end

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      pc_q <= `LC4_RESET_PC;
      o_fd <= '0;
    end else begin
      pc_q <= pc_n;
      if (i_redirect) begin
        o_fd.pc   <= pc_q;
        o_fd.insn <= '0;          // wrong-path fetch dropped
      end else if (!i_stall) begin
        o_fd.pc   <= pc_q;
        o_fd.insn <= i_insn;
      end
    end
  end

  assign o_pc = pc_q;

  // a load stall holds the pc for one cycle and then decode lets fetch move on
  assert property (@(posedge gwe) disable iff (i_rst)
    (i_stall && !i_redirect) |=> $stable(pc_q) && !i_stall)
    else $error("pc not held for exactly one load stall cycle");

endmodule

// File: logic/lc4_core.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module lc4_core import lc4_pkg::*; (
  input  logic                   gwe,
  input  logic                   i_rst,
  output logic [`LC4_WORD_W-1:0] o_pc,
  input  logic [`LC4_WORD_W-1:0] i_insn,
  output logic [`LC4_WORD_W-1:0] o_dmem_addr,
  output logic                   o_dmem_we,
  output logic [`LC4_WORD_W-1:0] o_dmem_wdata,
  input  logic [`LC4_WORD_W-1:0] i_dmem_rdata,
  output trace_t                 o_trace
);

  fd_t                    fd;
  dx_t                    dx;
  xm_t                    xm;
  fwd_t                   m_fwd;
  fwd_t                   w_fwd;           // also the regfile write port
  logic                   stall;
  logic                   redirect;
  logic [`LC4_WORD_W-1:0] target;
  logic [2:0]             nzp;

  fetch_unit fetch0 (
    .gwe        (gwe),
    .i_rst      (i_rst),
    .i_stall    (stall),
    .i_redirect (redirect),
    .i_target   (target),
    .i_insn     (i_insn),
    .o_pc       (o_pc),
    .o_fd       (fd)
  );

  decode_stage decode0 (
    .gwe        (gwe),
    .i_rst      (i_rst),
    .i_fd       (fd),
    .i_wr       (w_fwd),
    .i_redirect (redirect),
    .o_stall    (stall),
    .o_dx       (dx)
  );

  execute_stage execute0 (
    .gwe        (gwe),
    .i_rst      (i_rst),
    .i_dx       (dx),
    .i_m_fwd    (m_fwd),
    .i_w_fwd    (w_fwd),
    .i_nzp      (nzp),
    .o_redirect (redirect),
    .o_target   (target),
    .o_xm       (xm)
  );

  mem_wb_stage mem_wb0 (
    .gwe          (gwe),
    .i_rst        (i_rst),
    .i_xm         (xm),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_m_fwd      (m_fwd),
    .o_w_fwd      (w_fwd),
    .o_nzp        (nzp),
    .o_trace      (o_trace)
  );

endmodule

// File: logic/mem_wb_stage.sv
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module mem_wb_stage import lc4_pkg::*; (
  input  logic                   gwe,
  input  logic                   i_rst,
  input  xm_t                    i_xm,
  input  logic [`LC4_WORD_W-1:0] i_dmem_rdata,
  output logic [`LC4_WORD_W-1:0] o_dmem_addr,
  output logic [`LC4_WORD_W-1:0] o_dmem_wdata,
  output logic                   o_dmem_we,
  output fwd_t                   o_m_fwd,
  output fwd_t                   o_w_fwd,
  output logic [2:0]             o_nzp,
  output trace_t                 o_trace
);

  xm_t                    wb_q;
  logic [`LC4_WORD_W-1:0] rdata_q;     // load data from the memory cycle
  logic [`LC4_WORD_W-1:0] w_result;
  logic [2:0]             w_nzp;
  logic [2:0]             nzp_q;
  logic                   m_access;
  logic                   w_access;

  assign m_access     = i_xm.ctrl.is_load || i_xm.ctrl.is_store;
  assign o_dmem_addr  = m_access ? i_xm.result : '0;
  assign o_dmem_we    = i_xm.ctrl.is_store;
  assign o_dmem_wdata = i_xm.ctrl.is_store ? i_xm.store_data : '0;

  // load data arrives too late to bypass from here
  assign o_m_fwd.we   = i_xm.ctrl.regfile_we && !i_xm.ctrl.is_load;
  assign o_m_fwd.wsel = i_xm.ctrl.wsel;
  assign o_m_fwd.data = i_xm.result;

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      wb_q       <= '0;
      wb_q.stall <= `LC4_STALL_FLUSH;
      nzp_q      <= 3'b000;
    end else begin
      wb_q <= i_xm;
      if (wb_q.ctrl.nzp_we) begin
        nzp_q <= w_nzp;
      end
    end
  end

  always_ff @(posedge gwe) begin
    rdata_q <= i_dmem_rdata;
  end

  assign w_result = wb_q.ctrl.is_load ? rdata_q : wb_q.result;
  assign w_nzp    = wb_q.ctrl.is_load ? nzp_of(w_result) : wb_q.nzp;
  assign w_access = wb_q.ctrl.is_load || wb_q.ctrl.is_store;

  assign o_w_fwd.we   = wb_q.ctrl.regfile_we;
  assign o_w_fwd.wsel = wb_q.ctrl.wsel;
  assign o_w_fwd.data = w_result;
  assign o_nzp        = nzp_q;

  assign o_trace.pc         = wb_q.pc;
  assign o_trace.insn       = wb_q.insn;
  assign o_trace.stall      = wb_q.stall;
  assign o_trace.regfile_we = wb_q.ctrl.regfile_we;
  assign o_trace.wsel       = wb_q.ctrl.wsel;
  assign o_trace.wdata      = wb_q.ctrl.regfile_we ? w_result : '0;
  assign o_trace.nzp_we     = wb_q.ctrl.nzp_we;
  assign o_trace.nzp        = wb_q.ctrl.nzp_we ? w_nzp : 3'b000;
  assign o_trace.dmem_we    = wb_q.ctrl.is_store;
  assign o_trace.dmem_addr  = w_access ? wb_q.result : '0;
  assign o_trace.dmem_data  = wb_q.ctrl.is_load  ? rdata_q :
                              wb_q.ctrl.is_store ? wb_q.store_data : '0;

  // a store leaving memory must not turn into a register write
  assert property (@(posedge gwe) disable iff (i_rst) o_dmem_we |=> !o_w_fwd.we)
    else $error("store wrote the register file");

endmodule

// File: tb.f
+incdir+common
+incdir+bench
common/lc4_pkg.sv
logic/fetch_unit.sv
decode/regfile.sv
decode/decode_stage.sv
execute/execute_stage.sv
logic/mem_wb_stage.sv
logic/lc4_core.sv
bench/tb_lc4.sv
